// ==== all.f ====
hdl/uop_pkg.sv
hdl/bru_pkg.sv
hdl/bru_issue_stage.sv
hdl/bru_ins_decoder.sv
hdl/bru_resolve_stage.sv
hdl/bru_top.sv
dv/bru_tb.sv

// ==== Bender.yml ====
package:
  name: bru

sources:
  - files:
      - hdl/uop_pkg.sv
      - hdl/bru_pkg.sv
      - hdl/bru_issue_stage.sv
      - hdl/bru_ins_decoder.sv
      - hdl/bru_resolve_stage.sv
      - hdl/bru_top.sv
  - target: simulation
    files:
      - dv/bru_tb.sv

// ==== dv/bru_tb.sv ====
`default_nettype none

module bru_tb
    import uop_pkg::*;
    import bru_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int MIXED_CYCLES = 2000;
    localparam int WAIT_LIMIT   = 20;

    typedef struct packed {
        bru_resolve_t    res;
        RegFileWritePort wr;
    } expect_t;

    logic                 clk;
    logic                 rst;
    rob_issue             issue_in;
    logic [3:0]           nzcv;
    bru_resolve_t         resolve_out;
    RegFileWritePort      reg_wr_out;
    logic                 branch_done;

    expect_t              exp_q[$];  // One entry per driven cycle
    logic                 check_on;
    logic [ROB_TAG_W-1:0] next_tag;

    bru_top u_bru_top (
        .clk         (clk),
        .rst         (rst),
        .issue_in    (issue_in),
        .nzcv        (nzcv),
        .resolve_out (resolve_out),
        .reg_wr_out  (reg_wr_out),
        .branch_done (branch_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_value(input string sig, input logic [XLEN-1:0] exp_v,
                                input logic [XLEN-1:0] got_v);
        abort_run($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                            $time, sig, exp_v, got_v));
    endtask

    // Condition rule on the raw 4-bit code
    function automatic logic cond_holds(input logic [3:0] code, input logic [3:0] flags);
        logic n;
        logic z;
        logic v;
        n = flags[FLAG_N];
        z = flags[FLAG_Z];
        v = flags[FLAG_V];
        if (code == 4'b0000) return z;                     // EQ
        else if (code == 4'b0001) return !z;               // NE
        else if (code == 4'b1010) return n == v;           // GE
        else if (code == 4'b1011) return n != v;           // LT
        else if (code == 4'b1100) return !z && (n == v);   // GT
        else if (code == 4'b1101) return z || (n != v);    // LE
        else return 1'b0;
    endfunction

    function automatic void expect_resolve(input rob_issue iss, input logic [3:0] flags,
                                           output bru_resolve_t res,
                                           output RegFileWritePort wr);
        logic [XLEN-1:0] target;
        logic            taken;
        target = iss.pc + (iss.r2_val << 2);  // Word offset to bytes
        taken  = 1'b0;
        wr     = '0;
        if (iss.valid && iss.uop.uopcode == UOP_BL) begin
            taken       = 1'b1;
            wr.en       = 1'b1;
            wr.index_in = iss.dest_reg_phys;
            wr.data_in  = iss.pc + 64'd4;  // Return address
        end else if (iss.valid && iss.uop.uopcode == UOP_BCOND) begin
            taken = cond_holds(iss.uop.condition, flags);
        end
        res             = '0;
        res.valid       = iss.valid;
        res.rob_tag     = iss.rob_tag;
        res.taken       = taken;
        res.redirect_pc = taken ? target : iss.pc + 64'd4;
        res.mispredict  = (taken != iss.pred_taken) ||
                          (taken && iss.pred_taken && target != iss.pred_target);
    endfunction

    function automatic rob_issue random_issue(input uop_opcode_e op);
        rob_issue    iss;
        logic [3:0]  cond;
        logic [25:0] imm;
        cond              = 4'($urandom);
        imm               = 26'($urandom);
        iss               = '0;
        iss.valid         = 1'b1;
        iss.uop.uopcode   = op;
        iss.uop.condition = cond_code_e'(cond);
        iss.dest_reg_phys = PREG_W'($urandom);
        iss.r2_val        = {{(XLEN-26){imm[25]}}, imm};
        iss.pc            = {$urandom, $urandom} & ~64'h3;
        return iss;
    endfunction

    // Picks a frontend prediction that is right, wrong in direction or wrong in target
    function automatic rob_issue predict(input rob_issue iss, input logic [3:0] flags);
        bru_resolve_t    res;
        RegFileWritePort wr;
        rob_issue        p;
        int              mode;
        p = iss;
        expect_resolve(iss, flags, res, wr);
        mode = $urandom % 4;
        case (mode)
            0: begin
                p.pred_taken  = res.taken;
                p.pred_target = res.taken ? res.redirect_pc : {$urandom, $urandom};
            end
            1: begin
                p.pred_taken  = ~res.taken;
                p.pred_target = res.redirect_pc;
            end
            2: begin
                p.pred_taken  = 1'b1;
                p.pred_target = res.redirect_pc + 64'd8;  // Stale target when taken
            end
            default: begin
                p.pred_taken  = 1'($urandom);
                p.pred_target = {$urandom, $urandom};
            end
        endcase
        return p;
    endfunction

    task automatic drive_cycle(input rob_issue iss, input logic [3:0] flags);
        expect_t e;
        @(posedge clk);
        #1;
        if (iss.valid) begin
            iss.rob_tag = next_tag;
            next_tag    = next_tag + 1'b1;
        end
        issue_in = iss;
        nzcv     = flags;
        expect_resolve(iss, flags, e.res, e.wr);
        exp_q.push_back(e);
    endtask

    // Junk payload with valid low must be ignored
    task automatic drive_idle();
        rob_issue iss;
        iss       = random_issue(UOP_BL);
        iss.valid = 1'b0;
        drive_cycle(iss, 4'($urandom));
    endtask

    task automatic send_random(input uop_opcode_e op);
        logic [3:0] flags;
        flags = 4'($urandom);
        drive_cycle(predict(random_issue(op), flags), flags);
    endtask

    task automatic measure_latency(input rob_issue iss, input logic [3:0] flags);
        int cycles;
        drive_idle();
        drive_cycle(iss, flags);
        cycles = 0;
        do begin
            drive_idle();
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("Timed out waiting for resolve_out.valid after a BL issue");
            end
        end while (!resolve_out.valid);
        assert (cycles == 2) else report_value("resolve latency", 64'd2, cycles);
    endtask

    task automatic check_outputs(input expect_t e, input logic next_valid);
        assert (resolve_out.valid == e.res.valid)
            else report_value("resolve_out.valid", e.res.valid, resolve_out.valid);
        assert (reg_wr_out.en == e.wr.en)
            else report_value("reg_wr_out.en", e.wr.en, reg_wr_out.en);
        assert (branch_done == next_valid)
            else report_value("branch_done", next_valid, branch_done);
        if (e.res.valid) begin
            assert (resolve_out.rob_tag == e.res.rob_tag)
                else report_value("resolve_out.rob_tag", e.res.rob_tag, resolve_out.rob_tag);
            assert (resolve_out.taken == e.res.taken)
                else report_value("resolve_out.taken", e.res.taken, resolve_out.taken);
            assert (resolve_out.mispredict == e.res.mispredict)
                else report_value("resolve_out.mispredict", e.res.mispredict,
                                  resolve_out.mispredict);
            assert (resolve_out.redirect_pc == e.res.redirect_pc)
                else report_value("resolve_out.redirect_pc", e.res.redirect_pc,
                                  resolve_out.redirect_pc);
        end
        if (e.wr.en) begin
            assert (reg_wr_out.index_in == e.wr.index_in)
                else report_value("reg_wr_out.index_in", e.wr.index_in, reg_wr_out.index_in);
            assert (reg_wr_out.data_in == e.wr.data_in)
                else report_value("reg_wr_out.data_in", e.wr.data_in, reg_wr_out.data_in);
        end
    endtask

    // Front entry is two cycles old, the next one is in the issue register
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (check_on && exp_q.size() >= 3) begin
            e = exp_q.pop_front();
            check_outputs(e, exp_q[0].res.valid);
        end
    end

    initial begin
        rob_issue iss;
        int       sel;
        int       waited;
        void'($urandom(32'hd526_0879));
        issue_in = '0;
        nzcv     = '0;
        rst      = 1'b1;
        check_on = 1'b0;
        next_tag = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) exp_q.push_back('0);  // Cycles still under reset
        check_on = 1'b1;

        repeat (20) drive_idle();

        // Every condition code against every flag pattern
        for (int c = 0; c < 16; c++) begin
            for (int f = 0; f < 16; f++) begin
                iss = random_issue(UOP_BCOND);
                iss.uop.condition = cond_code_e'(4'(c));
                drive_cycle(predict(iss, 4'(f)), 4'(f));
            end
        end

        iss = random_issue(UOP_BL);
        iss.r2_val = 64'd5;
        measure_latency(predict(iss, 4'h0), 4'h0);
        iss = random_issue(UOP_BL);
        iss.r2_val = 64'hffff_ffff_ffff_fffd;  // -3 words
        measure_latency(predict(iss, 4'hf), 4'hf);
        repeat (100) send_random(UOP_BL);

        for (int i = 0; i < 400; i++) begin
            send_random((i % 2 == 0) ? UOP_BCOND : UOP_BL);
        end

        for (int i = 0; i < MIXED_CYCLES; i++) begin
            sel = $urandom % 8;
            case (sel)
                0, 1:    drive_idle();
                2:       send_random(UOP_NOP);
                3:       send_random(UOP_ALU);
                4, 5:    send_random(UOP_BCOND);
                default: send_random(UOP_BL);
            endcase
        end

        repeat (4) drive_idle();
        waited = 0;
        while (exp_q.size() >= 3) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timed out draining the queue of expected results");
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/bru_top.sv ====
`default_nettype none

module bru_top
    import bru_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    // Issue from ROB, one micro-op per cycle, no back-pressure
    input  rob_issue        issue_in,
    input  logic [3:0]      nzcv,

    // Resolution, two cycles after issue
    output bru_resolve_t    resolve_out,
    output RegFileWritePort reg_wr_out,

    // Early completion, one cycle ahead of resolve_out.valid
    output logic            branch_done
);

    bru_stage_t  stage_q;
    bru_result_t result;

    bru_issue_stage u_issue (
        .clk      (clk),
        .rst      (rst),
        .issue_in (issue_in),
        .nzcv     (nzcv),
        .stage_q  (stage_q)
    );

    // Purely combinational, sits between the two registers
    bru_ins_decoder u_decoder (
        .stage     (stage_q),
        .result    (result),
        .ready_out (branch_done)
    );

    bru_resolve_stage u_resolve (
        .clk         (clk),
        .rst         (rst),
        .result      (result),
        .resolve_out (resolve_out),
        .reg_wr_out  (reg_wr_out)
    );

endmodule

`default_nettype wire

// ==== hdl/bru_resolve_stage.sv ====
`default_nettype none

module bru_resolve_stage
    import bru_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    // From decoder
    input  bru_result_t     result,

    // To ROB and frontend
    output bru_resolve_t    resolve_out,

    // To register file
    output RegFileWritePort reg_wr_out
);

    logic            dir_wrong;
    logic            tgt_wrong;
    logic [XLEN-1:0] fall_through;
    bru_resolve_t    resolve_d;

    // Wrong direction always redirects
    assign dir_wrong = result.taken != result.pred_taken;

    // Right direction but a stale target from the BTB
    assign tgt_wrong = result.taken && result.pred_taken &&
                       (result.target != result.pred_target);

    assign fall_through = result.pc + INSN_BYTES;

    always_comb begin
        resolve_d            = '0;
        resolve_d.valid      = result.valid;
        resolve_d.rob_tag    = result.rob_tag;
        resolve_d.taken      = result.taken;
        resolve_d.mispredict = dir_wrong | tgt_wrong;
        resolve_d.redirect_pc = result.taken ? result.target : fall_through;
    end

    always_ff @(posedge clk) begin
        resolve_out <= resolve_d;
        reg_wr_out  <= result.reg_wr;
        if (rst) begin
            resolve_out.valid <= 1'b0;  // Strobes only
            reg_wr_out.en     <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bru_ins_decoder.sv ====
`default_nettype none

module bru_ins_decoder
    import uop_pkg::*;
    import bru_pkg::*;
(
    // From issue stage
    input  bru_stage_t  stage,

    // To resolve stage
    output bru_result_t result,

    // Early completion to ROB
    output logic        ready_out
);

    logic            is_bcond;
    logic            is_bl;
    logic            flag_n;
    logic            flag_z;
    logic            flag_v;
    logic [XLEN-1:0] offset;
    logic [XLEN-1:0] target;
    cond_code_e      cond;

    assign is_bcond = stage.issue.uop.uopcode == UOP_BCOND;
    assign is_bl    = stage.issue.uop.uopcode == UOP_BL;
    assign cond     = stage.issue.uop.condition;

    assign flag_n = stage.nzcv[FLAG_N];
    assign flag_z = stage.nzcv[FLAG_Z];
    assign flag_v = stage.nzcv[FLAG_V];

    // Word offset to byte offset, sign kept
    assign offset = $unsigned($signed(stage.issue.r2_val) <<< 2);
    assign target = stage.issue.pc + offset;

    function automatic logic cond_passed(input cond_code_e c, input logic n,
                                         input logic z, input logic v);
        case (c)
            COND_EQ: return z;
            COND_NE: return ~z;
            COND_GE: return ~(n ^ v);
            COND_LT: return n ^ v;
            COND_GT: return ~z & ~(n ^ v);
            COND_LE: return z | (n ^ v);
            default: return 1'b0;  // Not evaluated here
        endcase
    endfunction

    assign ready_out = stage.issue.valid;

    always_comb begin
        result             = '0;
        result.valid       = stage.issue.valid;
        result.rob_tag     = stage.issue.rob_tag;
        result.pc          = stage.issue.pc;
        result.pred_taken  = stage.issue.pred_taken;
        result.pred_target = stage.issue.pred_target;

        if (stage.issue.valid && is_bl) begin
            result.taken  = 1'b1;
            result.target = target;

            // Return address into the register renamed as X30
            result.reg_wr.en       = 1'b1;
            result.reg_wr.index_in = stage.issue.dest_reg_phys;
            result.reg_wr.data_in  = stage.issue.pc + INSN_BYTES;
        end else if (stage.issue.valid && is_bcond) begin
            result.taken  = cond_passed(cond, flag_n, flag_z, flag_v);
            result.target = target;
        end
        // Anything else falls through, not taken, no write
    end

endmodule

`default_nettype wire

// ==== hdl/bru_issue_stage.sv ====
`default_nettype none

module bru_issue_stage
    import bru_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // From ROB
    input  rob_issue   issue_in,
    input  logic [3:0] nzcv,

    // To decoder
    output bru_stage_t stage_q
);

    bru_stage_t stage_d;

    // Flags travel with the micro-op so the condition is checked
    // against the state that belonged to this issue
    always_comb begin
        stage_d       = '0;
        stage_d.issue = issue_in;
        stage_d.nzcv  = nzcv;
    end

    // Payload loads every cycle, only the valid bit is reset
    always_ff @(posedge clk) begin
        stage_q <= stage_d;
        if (rst) begin
            stage_q.issue.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bru_pkg.sv ====
`default_nettype none

package bru_pkg;

    import uop_pkg::*;

    localparam int XLEN      = 64;
    localparam int PREG_W    = 7;
    localparam int ROB_TAG_W = 6;

    // Bit positions inside the NZCV input
    localparam int FLAG_N = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_V = 3;

    // Fixed instruction size, used for the return address and fall-through
    localparam logic [XLEN-1:0] INSN_BYTES = 64'd4;

    // One branch micro-op as issued by the ROB
    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] rob_tag;
        uop_t                 uop;
        logic [PREG_W-1:0]    dest_reg_phys;  // Physical reg behind X30 for BL
        logic [XLEN-1:0]      r2_val;         // Branch offset in words
        logic [XLEN-1:0]      pc;
        logic                 pred_taken;
        logic [XLEN-1:0]      pred_target;
    } rob_issue;

    typedef struct packed {
        logic              en;
        logic [PREG_W-1:0] index_in;
        logic [XLEN-1:0]   data_in;
    } RegFileWritePort;

    // Issue stage to decoder
    typedef struct packed {
        rob_issue   issue;
        logic [3:0] nzcv;  // Flags captured with this issue
    } bru_stage_t;

    // Decoder to resolve stage
    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] rob_tag;
        logic [XLEN-1:0]      pc;
        logic                 taken;
        logic [XLEN-1:0]      target;
        logic                 pred_taken;
        logic [XLEN-1:0]      pred_target;
        RegFileWritePort      reg_wr;
    } bru_result_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] rob_tag;
        logic                 taken;
        logic                 mispredict;
        logic [XLEN-1:0]      redirect_pc;  // Where the frontend must restart
    } bru_resolve_t;

endpackage

`default_nettype wire

// ==== hdl/uop_pkg.sv ====
`default_nettype none

package uop_pkg;

    localparam int UOP_OPCODE_W = 4;
    localparam int COND_W       = 4;

    // Micro-op opcodes seen by the execution units
    typedef enum logic [UOP_OPCODE_W-1:0] {
        UOP_NOP   = 4'h0,
        UOP_BCOND = 4'h1,  // Conditional branch, B.cond
        UOP_BL    = 4'h2,  // Branch with link
        UOP_ALU   = 4'h3
    } uop_opcode_e;

    // ARM condition field
    // Only the signed compare group is evaluated by the branch unit,
    // the remaining encodings may still arrive and resolve as not taken
    typedef enum logic [COND_W-1:0] {
        COND_EQ = 4'b0000,  // Z set
        COND_NE = 4'b0001,  // Z clear
        COND_GE = 4'b1010,  // N == V
        COND_LT = 4'b1011,  // N != V
        COND_GT = 4'b1100,  // Z clear and N == V
        COND_LE = 4'b1101   // Z set or N != V
    } cond_code_e;

    typedef struct packed {
        uop_opcode_e uopcode;
        cond_code_e  condition;  // Meaningful for UOP_BCOND only
    } uop_t;

endpackage

`default_nettype wire
